//--- src/cache_pkg.sv
/*
 * geometry of the direct mapped cache, 16 lines of 8 words of 32 bits
 * byte address layout is tag, line, column and two ignored byte bits
 * address bits above the tag field are ignored by the cache
 */
package cache_pkg;

  // index widths and counts
  localparam int COL_BITS   = 3;
  localparam int LINE_BITS  = 4;
  localparam int COL_COUNT  = 1 << COL_BITS;
  localparam int LINE_COUNT = 1 << LINE_BITS;

  // 21-bit controller word address less line and column bits
  localparam int TAG_BITS = 14;

  // field positions in the host byte address
  localparam int COL_LSB  = 2;
  localparam int LINE_LSB = COL_LSB + COL_BITS;
  localparam int TAG_LSB  = LINE_LSB + LINE_BITS;

  // flags sit just above the tag, the rest of the word is unused
  typedef struct packed {
    logic [31-TAG_BITS-2:0] pad;
    logic                   dirty;
    logic                   valid;
    logic [TAG_BITS-1:0]    tag;
  } tag_fields_t;

  // raw word for the tag memory, field view for the hit and burst logic
  typedef union packed {
    logic [31:0] raw;
    tag_fields_t f;
  } tag_word_u;

endpackage

//--- src/sdrc_pkg.sv
/*
 * command port encodings of the SDRAM controller
 * the controller takes one command at a time and acks each one
 */
package sdrc_pkg;

  // 3-bit command codes
  localparam logic [2:0] CMD_REFRESH  = 3'b001;
  localparam logic [2:0] CMD_ACTIVATE = 3'b011;
  localparam logic [2:0] CMD_WRITE    = 3'b100;
  localparam logic [2:0] CMD_READ     = 3'b101;

  // data length field is words minus one, so eight words per burst
  localparam logic [7:0] BURST_LEN = 8'd7;

  // cycles between the read strobe and the first data word
  localparam int READ_WAIT = 4;
  localparam int ADDR_BITS = 21;

endpackage

//--- src/bram.sv
/*
 * byte-enabled word memory with one entry per cache line
 * read data is registered and returns the old word on a same-cycle write
 * contents rely on power-up initialization to zero
 */
module bram (
  input  logic                           clk,
  input  logic [3:0]                     we,
  input  logic [cache_pkg::LINE_BITS-1:0] addr,
  input  logic [31:0]                    wdata,
  output logic [31:0]                    rdata
);

  logic [31:0] mem [cache_pkg::LINE_COUNT];

  // all tags start invalid and clean
  initial begin
    for (int i = 0; i < cache_pkg::LINE_COUNT; i++) begin
      mem[i] = '0;
    end
  end

  // one enable per byte lane
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        mem[addr][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

//--- src/cache_lines.sv
/*
 * line store with one tag memory and eight column memories
 * all memories share the line index, so a whole line is read at once
 * fill_active hands every write port to the burst engine
 */
module cache_lines (
  input  logic                            clk,
  input  logic [cache_pkg::LINE_BITS-1:0] line_ix,
  input  logic [cache_pkg::COL_BITS-1:0]  col_ix,
  input  logic [3:0]                      host_we,
  input  logic [31:0]                     host_data,
  input  logic                            tag_host_we,
  input  cache_pkg::tag_word_u            tag_host_word,
  input  logic                            fill_active,
  input  logic [cache_pkg::COL_COUNT-1:0] fill_col_we,
  input  logic [31:0]                     fill_data,
  input  logic                            tag_fill_we,
  input  logic [cache_pkg::TAG_BITS-1:0]  fill_tag,
  output cache_pkg::tag_word_u            tag_word,
  output logic [31:0]                     col_words [cache_pkg::COL_COUNT]
);

  cache_pkg::tag_word_u fill_tag_word;
  logic [3:0]           tag_we;
  logic [31:0]          tag_wdata;
  logic [3:0]           col_we [cache_pkg::COL_COUNT];
  logic [31:0]          col_wdata;

  // a fetched line is valid and clean
  always_comb begin
    fill_tag_word       = '0;
    fill_tag_word.f.valid = 1'b1;
    fill_tag_word.f.tag   = fill_tag;
  end

  // write source select, burst fill or host
  always_comb begin
    if (fill_active) begin
      tag_we    = {4{tag_fill_we}};
      tag_wdata = fill_tag_word.raw;
      col_wdata = fill_data;
      // whole words, one column per strobe bit
      for (int i = 0; i < cache_pkg::COL_COUNT; i++) begin
        col_we[i] = {4{fill_col_we[i]}};
      end
    end else begin
      tag_we    = {4{tag_host_we}};
      tag_wdata = tag_host_word.raw;
      col_wdata = host_data;
      // host bytes only reach the addressed column
      for (int i = 0; i < cache_pkg::COL_COUNT; i++) begin
        col_we[i] = (int'(col_ix) == i) ? host_we : 4'b0000;
      end
    end
  end

  bram u_tag (
    .clk   (clk),
    .we    (tag_we),
    .addr  (line_ix),
    .wdata (tag_wdata),
    .rdata (tag_word)
  );

  // one memory per column, all indexed by line
  for (genvar i = 0; i < cache_pkg::COL_COUNT; i++) begin : g_col
    bram u_col (
      .clk   (clk),
      .we    (col_we[i]),
      .addr  (line_ix),
      .wdata (col_wdata),
      .rdata (col_words[i])
    );
  end

endmodule

//--- src/line_burst_ctrl.sv
/*
 * burst engine for dirty-line write-back and line fill
 * line_ix, req_tag and the stored tag must stay stable for a whole miss
 * one refresh is issued after reset before any miss is served
 */
module line_burst_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            miss,
  input  logic [cache_pkg::LINE_BITS-1:0] line_ix,
  input  logic [cache_pkg::TAG_BITS-1:0]  req_tag,
  input  cache_pkg::tag_word_u            tag_word,
  input  logic [31:0]                     col_words [cache_pkg::COL_COUNT],
  input  logic [31:0]                     sdrc_rdata,
  input  logic                            sdrc_cmd_ack,
  output logic                            fill_active,
  output logic [cache_pkg::COL_COUNT-1:0] fill_col_we,
  output logic [31:0]                     fill_data,
  output logic                            tag_fill_we,
  output logic                            sdrc_cmd_en,
  output logic [2:0]                      sdrc_cmd,
  output logic [sdrc_pkg::ADDR_BITS-1:0]  sdrc_addr,
  output logic [7:0]                      sdrc_data_len,
  output logic [31:0]                     sdrc_data
);

  typedef enum logic [3:0] {
    ST_INIT,
    ST_INIT_WAIT,
    ST_IDLE,
    ST_WB_ACT,
    ST_WB_DATA,
    ST_WB_ACK,
    ST_RD_ACT,
    ST_RD_WAIT,
    ST_RD_DATA,
    ST_RD_TAG,
    ST_RD_DONE
  } state_t;

  state_t                         state;
  logic [cache_pkg::COL_BITS-1:0] col;
  logic [2:0]                     wait_cnt;
  logic [sdrc_pkg::ADDR_BITS-1:0] old_addr;
  logic [sdrc_pkg::ADDR_BITS-1:0] new_addr;

  // first word of the stored line and of the requested line
  assign old_addr = {tag_word.f.tag, line_ix, {cache_pkg::COL_BITS{1'b0}}};
  assign new_addr = {req_tag, line_ix, {cache_pkg::COL_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= ST_INIT;
      sdrc_cmd_en <= 1'b0;
      fill_active <= 1'b0;
      fill_col_we <= '0;
      tag_fill_we <= 1'b0;
      col         <= '0;
      wait_cnt    <= '0;
    end else begin
      // command strobe is a single cycle
      sdrc_cmd_en <= 1'b0;
      case (state)
        ST_INIT: begin
          sdrc_cmd_en <= 1'b1;
          sdrc_cmd    <= sdrc_pkg::CMD_REFRESH;
          state       <= ST_INIT_WAIT;
        end
        ST_INIT_WAIT: begin
          if (sdrc_cmd_ack) begin
            state <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          // open the row of the old line if dirty, else of the new one
          if (miss) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd    <= sdrc_pkg::CMD_ACTIVATE;
            if (tag_word.f.dirty) begin
              sdrc_addr <= old_addr;
              state     <= ST_WB_ACT;
            end else begin
              sdrc_addr   <= new_addr;
              fill_active <= 1'b1;
              state       <= ST_RD_ACT;
            end
          end
        end
        ST_WB_ACT: begin
          // word 0 goes out together with the write strobe
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en   <= 1'b1;
            sdrc_cmd      <= sdrc_pkg::CMD_WRITE;
            sdrc_addr     <= old_addr;
            sdrc_data_len <= sdrc_pkg::BURST_LEN;
            sdrc_data     <= col_words[0];
            col           <= 1;
            state         <= ST_WB_DATA;
          end
        end
        ST_WB_DATA: begin
          // words 1 to 7 on back-to-back cycles
          sdrc_data <= col_words[col];
          col       <= col + 1'b1;
          if (&col) begin
            state <= ST_WB_ACK;
          end
        end
        ST_WB_ACK: begin
          // write burst done, open the row of the new line
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd    <= sdrc_pkg::CMD_ACTIVATE;
            sdrc_addr   <= new_addr;
            fill_active <= 1'b1;
            state       <= ST_RD_ACT;
          end
        end
        ST_RD_ACT: begin
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en   <= 1'b1;
            sdrc_cmd      <= sdrc_pkg::CMD_READ;
            sdrc_addr     <= new_addr;
            sdrc_data_len <= sdrc_pkg::BURST_LEN;
            wait_cnt      <= '0;
            state         <= ST_RD_WAIT;
          end
        end
        ST_RD_WAIT: begin
          // count runs from the strobe cycle, word 0 arrives READ_WAIT+1 later
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == 3'(sdrc_pkg::READ_WAIT + 1)) begin
            fill_data   <= sdrc_rdata;
            fill_col_we <= {{(cache_pkg::COL_COUNT-1){1'b0}}, 1'b1};
            col         <= 1;
            state       <= ST_RD_DATA;
          end
        end
        ST_RD_DATA: begin
          fill_data   <= sdrc_rdata;
          fill_col_we <= {{(cache_pkg::COL_COUNT-1){1'b0}}, 1'b1} << col;
          col         <= col + 1'b1;
          // tag goes in with the last column
          if (&col) begin
            tag_fill_we <= 1'b1;
            state       <= ST_RD_TAG;
          end
        end
        ST_RD_TAG: begin
          fill_col_we <= '0;
          tag_fill_we <= 1'b0;
          fill_active <= 1'b0;
          state       <= ST_RD_DONE;
        end
        ST_RD_DONE: begin
          // tag read register picks up the new tag here
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_INIT;
        end
      endcase
    end
  end

endmodule

//--- src/cache_sys.sv
/*
 * direct mapped write-back cache, 16 lines of 8 words, in front of an SDRAM controller
 * requester holds address, data and mask while busy is high and one cycle more
 * read data is valid one cycle after the address settles on a hit
 */
module cache_sys (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           enable,
  input  logic [31:0]                    address,
  input  logic [31:0]                    data_in,
  input  logic [3:0]                     write_enable,
  output logic [31:0]                    data_out,
  output logic                           data_out_ready,
  output logic                           busy,
  output logic                           sdrc_cmd_en,
  output logic [2:0]                     sdrc_cmd,
  output logic [sdrc_pkg::ADDR_BITS-1:0] sdrc_addr,
  output logic [7:0]                     sdrc_data_len,
  output logic [31:0]                    sdrc_data,
  input  logic [31:0]                    sdrc_rdata,
  input  logic                           sdrc_cmd_ack,
  input  logic                           sdrc_init_done
);

  logic [cache_pkg::COL_BITS-1:0]  col_ix;
  logic [cache_pkg::LINE_BITS-1:0] line_ix;
  logic [cache_pkg::LINE_BITS-1:0] line_q;
  logic [cache_pkg::TAG_BITS-1:0]  req_tag;
  cache_pkg::tag_word_u            tag_word;
  cache_pkg::tag_word_u            tag_host_word;
  logic [31:0]                     col_words [cache_pkg::COL_COUNT];
  logic                            tag_match;
  logic                            hit;
  logic                            miss;
  logic                            fill_active;
  logic [cache_pkg::COL_COUNT-1:0] fill_col_we;
  logic [31:0]                     fill_data;
  logic                            tag_fill_we;

  assign col_ix  = address[cache_pkg::COL_LSB +: cache_pkg::COL_BITS];
  assign line_ix = address[cache_pkg::LINE_LSB +: cache_pkg::LINE_BITS];
  assign req_tag = address[cache_pkg::TAG_LSB +: cache_pkg::TAG_BITS];

  // line the memories were read at, stored tag is stale until it matches
  always_ff @(posedge clk) begin
    line_q <= line_ix;
  end

  assign tag_match = tag_word.f.valid && (tag_word.f.tag == req_tag);
  assign hit       = (line_q == line_ix) && tag_match;
  // no miss on a stale tag or before the controller is up
  assign miss      = enable && sdrc_init_done && (line_q == line_ix) && !tag_match;

  assign busy           = enable && !hit;
  assign data_out_ready = enable && hit && (write_enable == 4'b0000);
  assign data_out       = col_words[col_ix];

  // write hit sets the line dirty
  always_comb begin
    tag_host_word         = '0;
    tag_host_word.f.dirty = 1'b1;
    tag_host_word.f.valid = 1'b1;
    tag_host_word.f.tag   = req_tag;
  end

  cache_lines u_lines (
    .clk           (clk),
    .line_ix       (line_ix),
    .col_ix        (col_ix),
    .host_we       ((enable && hit) ? write_enable : 4'b0000),
    .host_data     (data_in),
    .tag_host_we   (enable && hit && (|write_enable)),
    .tag_host_word (tag_host_word),
    .fill_active   (fill_active),
    .fill_col_we   (fill_col_we),
    .fill_data     (fill_data),
    .tag_fill_we   (tag_fill_we),
    .fill_tag      (req_tag),
    .tag_word      (tag_word),
    .col_words     (col_words)
  );

  line_burst_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss          (miss),
    .line_ix       (line_ix),
    .req_tag       (req_tag),
    .tag_word      (tag_word),
    .col_words     (col_words),
    .sdrc_rdata    (sdrc_rdata),
    .sdrc_cmd_ack  (sdrc_cmd_ack),
    .fill_active   (fill_active),
    .fill_col_we   (fill_col_we),
    .fill_data     (fill_data),
    .tag_fill_we   (tag_fill_we),
    .sdrc_cmd_en   (sdrc_cmd_en),
    .sdrc_cmd      (sdrc_cmd),
    .sdrc_addr     (sdrc_addr),
    .sdrc_data_len (sdrc_data_len),
    .sdrc_data     (sdrc_data)
  );

endmodule

//--- test/sdrc_model.sv
/*
 * behavioral SDRAM controller, one command at a time, no bank timing
 * unwritten words read as a fixed pattern of the word address
 * every written word is also reported on the wb_* outputs
 */
module sdrc_model (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_en,
  input  logic [2:0]                     cmd,
  input  logic [sdrc_pkg::ADDR_BITS-1:0] addr,
  input  logic [31:0]                    data,
  output logic [31:0]                    rdata,
  output logic                           cmd_ack,
  output logic                           init_done,
  output logic                           wb_valid,
  output logic [sdrc_pkg::ADDR_BITS-1:0] wb_addr,
  output logic [31:0]                    wb_data,
  output logic [2:0]                     first_cmd
);

  logic [31:0]                    mem [int];
  logic [2:0]                     op;
  logic [sdrc_pkg::ADDR_BITS-1:0] op_addr;
  int                             op_cnt;
  logic                           op_busy;
  logic                           first_seen;

  // same scrambled pattern as the reference memory in the testbench
  function automatic logic [31:0] pattern_word(input logic [sdrc_pkg::ADDR_BITS-1:0] a);
    return (32'(a) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] read_word(input logic [sdrc_pkg::ADDR_BITS-1:0] a);
    if (mem.exists(int'(a))) begin
      return mem[int'(a)];
    end
    return pattern_word(a);
  endfunction

  // op_cnt equals the cycles elapsed since the strobe cycle
  always @(posedge clk) begin
    if (!rst_n) begin
      cmd_ack    <= 1'b0;
      init_done  <= 1'b0;
      wb_valid   <= 1'b0;
      op_busy    <= 1'b0;
      first_seen <= 1'b0;
      first_cmd  <= 3'b000;
      rdata      <= '0;
    end else begin
      cmd_ack  <= 1'b0;
      wb_valid <= 1'b0;
      if (cmd_en) begin
        if (!first_seen) begin
          first_seen <= 1'b1;
          first_cmd  <= cmd;
        end
        op      <= cmd;
        op_addr <= addr;
        op_cnt  <= 1;
        op_busy <= 1'b1;
        // read ack one cycle after the strobe
        if (cmd == sdrc_pkg::CMD_READ) begin
          cmd_ack <= 1'b1;
        end
        // word 0 travels with the write strobe
        if (cmd == sdrc_pkg::CMD_WRITE) begin
          mem[int'(addr)] = data;
          wb_valid <= 1'b1;
          wb_addr  <= addr;
          wb_data  <= data;
        end
      end else if (op_busy) begin
        op_cnt <= op_cnt + 1;
        case (op)
          sdrc_pkg::CMD_READ: begin
            // word k appears READ_WAIT+1+k cycles after the strobe
            if (op_cnt >= sdrc_pkg::READ_WAIT && op_cnt < sdrc_pkg::READ_WAIT + 8) begin
              rdata <= read_word(op_addr + 21'(op_cnt - sdrc_pkg::READ_WAIT));
            end
            if (op_cnt == sdrc_pkg::READ_WAIT + 7) begin
              op_busy <= 1'b0;
            end
          end
          sdrc_pkg::CMD_WRITE: begin
            if (op_cnt >= 1 && op_cnt <= 7) begin
              mem[int'(op_addr) + op_cnt] = data;
              wb_valid <= 1'b1;
              wb_addr  <= op_addr + 21'(op_cnt);
              wb_data  <= data;
            end
            // ack three cycles after the last word
            if (op_cnt == 9) begin
              cmd_ack <= 1'b1;
              op_busy <= 1'b0;
            end
          end
          default: begin
            // refresh and activate ack after two cycles
            if (op_cnt == 1) begin
              cmd_ack <= 1'b1;
              op_busy <= 1'b0;
              if (op == sdrc_pkg::CMD_REFRESH) begin
                init_done <= 1'b1;
              end
            end
          end
        endcase
      end
    end
  end

endmodule

//--- test/cache_sys_tb.sv
/*
 * testbench for the cache in front of the behavioral SDRAM controller
 * rows of the table are applied in order, each held until busy falls plus one cycle
 * expected words come from a reference memory and a mirror of the tag state
 */
module cache_sys_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int DIRECT_COUNT = 7;
  localparam int ROW_COUNT    = 48;
  localparam int ROW_LIMIT    = 60;

  typedef struct packed {
    logic [3:0]  mask;
    logic [31:0] addr;
    logic [31:0] data;
  } row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic        sdrc_cmd_en;
  logic [2:0]  sdrc_cmd;
  logic [20:0] sdrc_addr;
  logic [7:0]  sdrc_data_len;
  logic [31:0] sdrc_data;
  logic [31:0] sdrc_rdata;
  logic        sdrc_cmd_ack;
  logic        sdrc_init_done;
  logic        wb_valid;
  logic [20:0] wb_addr;
  logic [31:0] wb_data;
  logic [2:0]  first_cmd;

  row_t        rows [ROW_COUNT];
  logic [31:0] ref_mem [int];
  logic        line_valid [16];
  logic [13:0] line_tag [16];
  int          check_count = 0;
  int          err_count = 0;
  int unsigned seed = 32'hd230_c19d;

  always #(CLK_PERIOD / 2) clk = ~clk;

  cache_sys uut (
    .clk(clk), .rst_n(rst_n), .enable(enable), .address(address),
    .data_in(data_in), .write_enable(write_enable), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy),
    .sdrc_cmd_en(sdrc_cmd_en), .sdrc_cmd(sdrc_cmd), .sdrc_addr(sdrc_addr),
    .sdrc_data_len(sdrc_data_len), .sdrc_data(sdrc_data),
    .sdrc_rdata(sdrc_rdata), .sdrc_cmd_ack(sdrc_cmd_ack),
    .sdrc_init_done(sdrc_init_done)
  );

  sdrc_model u_model (
    .clk(clk), .rst_n(rst_n), .cmd_en(sdrc_cmd_en), .cmd(sdrc_cmd),
    .addr(sdrc_addr), .data(sdrc_data),
    .rdata(sdrc_rdata), .cmd_ack(sdrc_cmd_ack), .init_done(sdrc_init_done),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .first_cmd(first_cmd)
  );

  // contents of SDRAM before any write
  function automatic logic [31:0] pattern_word(input logic [20:0] a);
    return (32'(a) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] expected_word(input logic [20:0] a);
    if (ref_mem.exists(int'(a))) begin
      return ref_mem[int'(a)];
    end
    return pattern_word(a);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("ERR %s: got %h expected %h", name, got, exp);
    end
  endtask

  // words leaving on a write-back must match the reference
  always @(negedge clk) begin
    if (wb_valid) begin
      check_value("sdrc write data", wb_data, expected_word(wb_addr));
    end
    // read and write bursts move a whole line, length field is words minus one
    if (sdrc_cmd_en && (sdrc_cmd == sdrc_pkg::CMD_READ ||
                        sdrc_cmd == sdrc_pkg::CMD_WRITE)) begin
      check_value("sdrc_data_len", 32'(sdrc_data_len), 32'(8 - 1));
    end
  end

  task automatic run_row(input row_t r);
    logic [20:0] wa;
    logic [3:0]  line;
    logic [13:0] tag;
    logic        exp_hit;
    logic [31:0] word;
    int          cycles;
    wa      = r.addr[22:2];
    line    = r.addr[8:5];
    tag     = r.addr[22:9];
    exp_hit = line_valid[line] && (line_tag[line] == tag);
    enable       = 1'b1;
    address      = r.addr;
    data_in      = r.data;
    write_enable = r.mask;
    // tag memory needs one edge to read the new line
    @(negedge clk);
    check_value("busy", 32'(busy), 32'(!exp_hit));
    cycles = 0;
    while (busy && cycles < ROW_LIMIT) begin
      check_value("data_out_ready", 32'(data_out_ready), 32'h0);
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      err_count++;
      $display("miss at address %h never finished, busy stayed high", r.addr);
    end
    if (r.mask == 4'h0) begin
      check_value("data_out_ready", 32'(data_out_ready), 32'h1);
      check_value("data_out", data_out, expected_word(wa));
    end else begin
      check_value("data_out_ready", 32'(data_out_ready), 32'h0);
    end
    // hold one more cycle, the write hit lands on this edge
    @(negedge clk);
    word = expected_word(wa);
    for (int b = 0; b < 4; b++) begin
      if (r.mask[b]) begin
        word[8*b +: 8] = r.data[8*b +: 8];
      end
    end
    ref_mem[int'(wa)] = word;
    line_valid[line]  = 1'b1;
    line_tag[line]    = tag;
    enable = 1'b0;
    @(negedge clk);
    check_value("busy", 32'(busy), 32'h0);
    check_value("data_out_ready", 32'(data_out_ready), 32'h0);
  endtask

  initial begin
    rst_n        = 1'b0;
    enable       = 1'b0;
    address      = '0;
    data_in      = '0;
    write_enable = 4'h0;
    void'($urandom(seed));
    for (int i = 0; i < 16; i++) begin
      line_valid[i] = 1'b0;
      line_tag[i]   = '0;
    end
    // miss, same-line hit, masked write, read back, dirty eviction, refetch, write miss
    rows[0] = '{4'h0, 32'h0000_0104, 32'h0};
    rows[1] = '{4'h0, 32'h0000_0110, 32'h0};
    rows[2] = '{4'h5, 32'h0000_0104, 32'haabb_ccdd};
    rows[3] = '{4'h0, 32'h0000_0104, 32'h0};
    rows[4] = '{4'h0, 32'h0000_2104, 32'h0};
    rows[5] = '{4'h0, 32'h0000_0104, 32'h0};
    rows[6] = '{4'hf, 32'h0000_0308, 32'h1234_5678};
    // three tags per line give a mix of hits and evictions
    for (int i = DIRECT_COUNT; i < ROW_COUNT; i++) begin
      rows[i].addr = ((32'($urandom % 3)) << 9) | ((32'($urandom % 16)) << 5)
                   | ((32'($urandom % 8)) << 2);
      rows[i].mask = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom % 16);
      rows[i].data = $urandom;
    end
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_value("busy", 32'(busy), 32'h0);
      check_value("data_out_ready", 32'(data_out_ready), 32'h0);
    end
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < ROW_COUNT; i++) begin
      run_row(rows[i]);
    end
    check_value("first_cmd", 32'(first_cmd), 32'(sdrc_pkg::CMD_REFRESH));
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + ROW_LIMIT * ROW_COUNT));
    $display("timeout, the rows did not complete in time");
    $display("checks %0d, errors %0d", check_count, err_count + 1);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- cache_sys.f
src/cache_pkg.sv
src/sdrc_pkg.sv
src/bram.sv
src/cache_lines.sv
src/line_burst_ctrl.sv
src/cache_sys.sv
test/sdrc_model.sv
test/cache_sys_tb.sv
